/* common/chanlink_pkg.sv */
`default_nettype none

package chanlink_pkg;

	localparam int adc_w     = 12;
	localparam int l1a_num_w = 24;
	localparam int crc_w     = 15;
	localparam int frame_w   = 16;

	localparam logic [frame_w-1:0] marker_mid  = 16'h700C;
	localparam logic [frame_w-1:0] marker_end  = 16'h7FFF;
	localparam logic [3:0]         trailer_nib = 4'h7;

	// Word kinds issued by the sequencer
	localparam logic [2:0] wk_sample  = 3'd0;
	localparam logic [2:0] wk_crc     = 3'd1;
	localparam logic [2:0] wk_mid     = 3'd2;
	localparam logic [2:0] wk_trailer = 3'd3;
	localparam logic [2:0] wk_end     = 3'd4;

	// One output word, seen as a sample or as a trailer
	typedef union packed {
		struct packed {
			logic              spare_hi; // Always 0
			logic              novlp;
			logic              serial;
			logic              spare_lo; // Always 0
			logic [adc_w-1:0]  data;
		} smp;
		struct packed {
			logic [3:0] tag;
			logic [5:0] l1a_lo;
			logic [4:0] l1a_occ;
			logic       warn;
		} trl;
	} frame_word_u;

	// CRC-15 step over one 13-bit word
	function automatic logic [crc_w-1:0] crc15_d13(input logic [12:0] d,
		input logic [crc_w-1:0] c);
		logic [crc_w-1:0] n;
		n[0]  = d[0] ^ c[2];
		n[1]  = d[0] ^ d[1] ^ c[2] ^ c[3];
		n[2]  = d[1] ^ d[2] ^ c[3] ^ c[4];
		n[3]  = d[2] ^ d[3] ^ c[4] ^ c[5];
		n[4]  = d[3] ^ d[4] ^ c[5] ^ c[6];
		n[5]  = d[4] ^ d[5] ^ c[6] ^ c[7];
		n[6]  = d[5] ^ d[6] ^ c[7] ^ c[8];
		n[7]  = d[6] ^ d[7] ^ c[8] ^ c[9];
		n[8]  = d[7] ^ d[8] ^ c[9] ^ c[10];
		n[9]  = d[8] ^ d[9] ^ c[10] ^ c[11];
		n[10] = d[9] ^ d[10] ^ c[11] ^ c[12];
		n[11] = d[10] ^ d[11] ^ c[12] ^ c[13];
		n[12] = d[11] ^ d[12] ^ c[13] ^ c[14];
		n[13] = d[12] ^ c[14] ^ c[0];
		n[14] = c[1];
		return n;
	endfunction

endpackage

`default_nettype wire

/* src/sync_fifo.sv */
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 14,
	parameter int DEPTH = 128
) (
	input  wire                       RCLK,
	input  wire                       RST_RESYNC,
	input  wire  [WIDTH-1:0]          wr_data,
	input  wire                       wr_en,
	input  wire                       rd_en,
	output logic [WIDTH-1:0]          rd_data,
	output logic                      full,
	output logic                      empty,
	output logic [$clog2(DEPTH):0]    count
);

	localparam int PTR_W = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_wr;
	logic             do_rd;

	assign full    = (count == ($clog2(DEPTH)+1)'(DEPTH));
	assign empty   = (count == '0);
	assign do_wr   = wr_en & ~full;  // Writes into a full FIFO are dropped
	assign do_rd   = rd_en & ~empty;
	assign rd_data = mem[rd_ptr];    // Head word falls through

	always_ff @(posedge RCLK) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// Pointers wrap at DEPTH-1
	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			count <= '0;
		end else begin
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

/* frame/frame_seq_fsm.sv */
`default_nettype none

module frame_seq_fsm import chanlink_pkg::*; #(
	parameter int SMP_DEPTH = 128
) (
	input  wire                          RCLK,
	input  wire                          RST_RESYNC,
	input  wire  [6:0]                   samp_max,
	input  wire  [$clog2(SMP_DEPTH):0]   smp_count,
	input  wire                          l1a_empty,
	input  wire                          slot_free,
	output logic                         smp_pop,
	output logic                         l1a_pop,
	output logic                         load,
	output logic [2:0]                   word_kind,
	output logic [6:0]                   smp_index,
	output logic                         first_smp
);

	localparam int CNT_W = $clog2(SMP_DEPTH) + 1;

	localparam logic [2:0] st_idle    = 3'd0;
	localparam logic [2:0] st_smp     = 3'd1;
	localparam logic [2:0] st_crc     = 3'd2;
	localparam logic [2:0] st_mid     = 3'd3;
	localparam logic [2:0] st_trailer = 3'd4;
	localparam logic [2:0] st_end     = 3'd5;

	logic [2:0] state;
	logic [2:0] state_d;
	logic [6:0] idx_q;
	logic [6:0] smax_q;    // samp_max held for the frame
	logic       start;

	// Whole event buffered and a trigger waiting
	assign start = ~l1a_empty & (smp_count > CNT_W'(samp_max)) & slot_free;

	//////////////////////////////////////////////////////////////////////
	// Next state and strobes
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		state_d   = state;
		load      = 1'b0;
		smp_pop   = 1'b0;
		l1a_pop   = 1'b0;
		first_smp = 1'b0;
		word_kind = wk_sample;
		smp_index = idx_q;
		case (state)
			st_idle: begin
				smp_index = 7'd0;
				if (start) begin
					load      = 1'b1;
					smp_pop   = 1'b1;
					first_smp = 1'b1;   // Clears CRC in builder
					state_d   = (samp_max == 7'd0) ? st_crc : st_smp;
				end
			end
			st_smp: begin
				load    = slot_free;
				smp_pop = slot_free;
				if (slot_free && idx_q == smax_q)
					state_d = st_crc;
			end
			st_crc: begin
				word_kind = wk_crc;
				load      = slot_free;
				if (slot_free)
					state_d = st_mid;
			end
			st_mid: begin
				word_kind = wk_mid;
				load      = slot_free;
				if (slot_free)
					state_d = st_trailer;
			end
			st_trailer: begin
				word_kind = wk_trailer;
				load      = slot_free;
				if (slot_free)
					state_d = st_end;
			end
			st_end: begin
				word_kind = wk_end;
				load      = slot_free;
				l1a_pop   = slot_free; // Trigger retired with the last word
				if (slot_free)
					state_d = st_idle;
			end
			default: state_d = st_idle;
		endcase
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state  <= st_idle;
			idx_q  <= 7'd0;
			smax_q <= 7'd0;
		end else begin
			state <= state_d;
			if (state == st_idle && start) begin
				smax_q <= samp_max;
				idx_q  <= 7'd1;
			end else if (state == st_smp && slot_free) begin
				idx_q <= idx_q + 7'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* frame/frame_builder.sv */
`default_nettype none

module frame_builder import chanlink_pkg::*; (
	input  wire                  RCLK,
	input  wire                  RST_RESYNC,
	input  wire                  load,
	input  wire  [2:0]           word_kind,
	input  wire  [6:0]           smp_index,
	input  wire                  first_smp,
	input  wire  [adc_w+1:0]     smp_head,    // {movlp, ovlp, data}
	input  wire  [l1a_num_w:0]   l1a_head,    // {phase, number}
	input  wire  [4:0]           l1a_count,
	input  wire                  warn,
	input  wire                  dout_ready,
	output logic                 slot_free,
	output logic [frame_w-1:0]   dout,
	output logic                 dout_valid,
	output logic                 mlt_ovlp,
	output logic                 last_wrd
);

	logic [adc_w-1:0]     smp_data;
	logic                 smp_ovlp;
	logic                 smp_movlp;
	logic [l1a_num_w-1:0] l1a_num;
	logic                 l1a_phase;
	logic [crc_w-1:0]     crc_q;
	logic [crc_w-1:0]     crc_base;
	logic                 warn_q;
	frame_word_u          fw;

	assign {smp_movlp, smp_ovlp, smp_data} = smp_head;
	assign {l1a_phase, l1a_num}            = l1a_head;

	assign slot_free = ~dout_valid | dout_ready;
	assign crc_base  = first_smp ? '0 : crc_q;

	//////////////////////////////////////////////////////////////////////
	// Word formation
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		fw = '0;
		case (word_kind)
			wk_sample: begin
				fw.smp.novlp  = ~smp_ovlp;
				fw.smp.serial = (smp_index < 7'd6) ? l1a_phase : 1'b0; // Phase on first six
				fw.smp.data   = smp_data;
			end
			wk_crc:  fw = {1'b0, crc_q};
			wk_mid:  fw = marker_mid;
			wk_trailer: begin
				fw.trl.tag     = trailer_nib;
				fw.trl.l1a_lo  = l1a_num[5:0];
				fw.trl.l1a_occ = l1a_count;  // Includes this event
				fw.trl.warn    = warn_q;
			end
			default: fw = marker_end;
		endcase
	end

	// CRC runs over the sample words only
	always_ff @(posedge RCLK) begin
		if (load && word_kind == wk_sample)
			crc_q <= crc15_d13({1'b0, smp_data}, crc_base);
		if (load)
			dout <= fw;
	end

	always_ff @(posedge RCLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			dout_valid <= 1'b0;
			mlt_ovlp   <= 1'b0;
			last_wrd   <= 1'b0;
			warn_q     <= 1'b0;
		end else begin
			if (load && first_smp)
				warn_q <= warn;          // Frame-start sample
			if (load) begin
				dout_valid <= 1'b1;
				mlt_ovlp   <= (word_kind == wk_sample) & smp_movlp;
				last_wrd   <= (word_kind == wk_end);
			end else if (dout_ready) begin
				dout_valid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* src/chanlink_fifo.sv */
`default_nettype none

module chanlink_fifo import chanlink_pkg::*; #(
	parameter int SMP_DEPTH = 128,
	parameter int L1A_DEPTH = 16,
	parameter int AFL_LEVEL = SMP_DEPTH - 8
) (
	input  wire                    RCLK,
	input  wire                    RST_RESYNC,
	input  wire  [6:0]             samp_max,
	input  wire                    warn,
	input  wire  [adc_w-1:0]       smp_data,
	input  wire                    smp_ovlp,
	input  wire                    smp_movlp,
	input  wire                    smp_valid,
	output logic                   smp_ready,
	input  wire  [l1a_num_w-1:0]   l1a_num,
	input  wire                    l1a_phase,
	input  wire                    l1a_valid,
	output logic                   l1a_ready,
	output logic [frame_w-1:0]     dout,
	output logic                   dout_valid,
	input  wire                    dout_ready,
	output logic                   mlt_ovlp,
	output logic                   last_wrd,
	output logic                   evt_buf_amt,
	output logic                   evt_buf_afl
);

	localparam int SCNT_W = $clog2(SMP_DEPTH) + 1;

	logic [adc_w+1:0]          smp_head;
	logic                      smp_full;
	logic [SCNT_W-1:0]         smp_count;
	logic                      smp_pop;
	logic [l1a_num_w:0]        l1a_head;
	logic                      l1a_full;
	logic                      l1a_empty;
	logic [$clog2(L1A_DEPTH):0] l1a_count;
	logic                      l1a_pop;
	logic                      load;
	logic [2:0]                word_kind;
	logic [6:0]                smp_index;
	logic                      first_smp;
	logic                      slot_free;

	assign smp_ready = ~smp_full;
	assign l1a_ready = ~l1a_full;

	// Less than one event buffered / buffer nearly full
	assign evt_buf_amt = (smp_count <= SCNT_W'(samp_max));
	assign evt_buf_afl = (smp_count >= SCNT_W'(AFL_LEVEL));

	sync_fifo #(.WIDTH(adc_w + 2), .DEPTH(SMP_DEPTH)) evt_buf_i (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.wr_data({smp_movlp, smp_ovlp, smp_data}), .wr_en(smp_valid),
		.rd_en(smp_pop), .rd_data(smp_head),
		.full(smp_full), .empty(), .count(smp_count)
	);

	sync_fifo #(.WIDTH(l1a_num_w + 1), .DEPTH(L1A_DEPTH)) l1a_buf_i (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.wr_data({l1a_phase, l1a_num}), .wr_en(l1a_valid),
		.rd_en(l1a_pop), .rd_data(l1a_head),
		.full(l1a_full), .empty(l1a_empty), .count(l1a_count)
	);

	frame_seq_fsm #(.SMP_DEPTH(SMP_DEPTH)) frame_seq_fsm_i (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.samp_max(samp_max), .smp_count(smp_count), .l1a_empty(l1a_empty),
		.slot_free(slot_free), .smp_pop(smp_pop), .l1a_pop(l1a_pop),
		.load(load), .word_kind(word_kind), .smp_index(smp_index), .first_smp(first_smp)
	);

	frame_builder frame_builder_i (
		.RCLK(RCLK), .RST_RESYNC(RST_RESYNC),
		.load(load), .word_kind(word_kind), .smp_index(smp_index), .first_smp(first_smp),
		.smp_head(smp_head), .l1a_head(l1a_head), .l1a_count(l1a_count), .warn(warn),
		.dout_ready(dout_ready), .slot_free(slot_free), .dout(dout),
		.dout_valid(dout_valid), .mlt_ovlp(mlt_ovlp), .last_wrd(last_wrd)
	);

endmodule

`default_nettype wire

/* bench/chanlink_fifo_tb.sv */
`default_nettype none

module chanlink_fifo_tb import chanlink_pkg::*; ();

	localparam int SMP_DEPTH = 128;
	localparam int L1A_DEPTH = 16;
	localparam int AFL_LEVEL = SMP_DEPTH - 8;

	logic                 RCLK        = 1'b0;
	logic                 RST_RESYNC  = 1'b1;
	logic [6:0]           samp_max    = '0;
	logic                 warn        = 1'b0;
	logic [adc_w-1:0]     smp_data    = '0;
	logic                 smp_ovlp    = 1'b0;
	logic                 smp_movlp   = 1'b0;
	logic                 smp_valid   = 1'b0;
	logic                 smp_ready;
	logic [l1a_num_w-1:0] l1a_num     = '0;
	logic                 l1a_phase   = 1'b0;
	logic                 l1a_valid   = 1'b0;
	logic                 l1a_ready;
	logic [frame_w-1:0]   dout;
	logic                 dout_valid;
	logic                 dout_ready  = 1'b0;
	logic                 mlt_ovlp;
	logic                 last_wrd;
	logic                 evt_buf_amt;
	logic                 evt_buf_afl;

	// Test records and their events from the data file
	string       t_name [16];
	int          t_smax [16];
	int          t_warn [16];
	int          t_stall [16];
	int          t_hold [16];
	int          t_nevt [16];
	int          t_words [16];
	logic [23:0] e_num [64];
	int          e_phase [64];
	int          e_base [64];
	int          e_step [64];
	int          e_oe [64];
	int          e_me [64];

	int          n_tests      = 0;
	int          n_evts       = 0;
	int          ev           = 0;
	int          smp_written  = 0;
	int          smp_popped   = 0;
	int          l1a_sent     = 0;
	int          l1a_done     = 0;
	int          limit_cycles = 0;
	int          seed         = 41913;
	logic        running      = 1'b0;
	logic        stall_on     = 1'b0;
	logic        hold_out     = 1'b0;
	logic        afl_seen     = 1'b0;
	string       cur_name     = "reset";
	logic [18:0] exp_q [$];   // {is_sample, last_wrd, mlt_ovlp, dout}
	logic [13:0] smp_q [$];   // {movlp, ovlp, data}

	always #2 RCLK = ~RCLK;

	chanlink_fifo #(.SMP_DEPTH(SMP_DEPTH), .L1A_DEPTH(L1A_DEPTH), .AFL_LEVEL(AFL_LEVEL))
		chanlink_fifo_i (.*);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic report_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		stop_run($sformatf("** Error %s: %s expected %h actual %h", cur_name, what, exp, act));
	endtask

	task automatic load_records();
		int    fd;
		int    code;
		string line;
		string nm;
		fd = $fopen("bench/chanlink_testdata.txt", "r");
		if (fd == 0)
			stop_run("Cannot open bench/chanlink_testdata.txt");
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 1 && line.getc(0) == "T") begin
				code = $sscanf(line, "T %s %d %d %d %d %d %d", nm, t_smax[n_tests],
					t_warn[n_tests], t_stall[n_tests], t_hold[n_tests],
					t_nevt[n_tests], t_words[n_tests]);
				if (code != 7)
					stop_run("Malformed test record in bench/chanlink_testdata.txt");
				t_name[n_tests] = nm;
				limit_cycles += t_words[n_tests] * 8;
				n_tests++;
			end else if (line.len() > 1 && line.getc(0) == "E") begin
				code = $sscanf(line, "E %h %d %h %d %d %d", e_num[n_evts], e_phase[n_evts],
					e_base[n_evts], e_step[n_evts], e_oe[n_evts], e_me[n_evts]);
				if (code != 6)
					stop_run("Malformed event record in bench/chanlink_testdata.txt");
				n_evts++;
			end
		end
		$fclose(fd);
		limit_cycles += 1000;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Expected frame for one event
	//////////////////////////////////////////////////////////////////////
	task automatic build_frame(input int e, input int occ, input int smax, input logic wbit);
		frame_word_u fw;
		logic [14:0] crc;
		logic [11:0] d;
		logic        ov;
		logic        mv;
		crc = '0;
		for (int i = 0; i <= smax; i++) begin
			d  = 12'(e_base[e] + i * e_step[e]);
			ov = (e_oe[e] != 0) && (i % e_oe[e] == 0);
			mv = (e_me[e] != 0) && (i % e_me[e] == e_me[e] - 1);
			fw = '0;
			fw.smp.novlp  = ~ov;
			fw.smp.serial = (i < 6) ? e_phase[e][0] : 1'b0; // Phase on first six only
			fw.smp.data   = d;
			crc = crc15_d13({1'b0, d}, crc);
			exp_q.push_back({1'b1, 1'b0, mv, fw});
			smp_q.push_back({mv, ov, d});
		end
		exp_q.push_back({3'b000, 1'b0, crc});
		exp_q.push_back({3'b000, marker_mid});
		fw = '0;
		fw.trl.tag     = trailer_nib;
		fw.trl.l1a_lo  = e_num[e][5:0];
		fw.trl.l1a_occ = 5'(occ);
		fw.trl.warn    = wbit;
		exp_q.push_back({3'b000, fw});
		exp_q.push_back({3'b010, marker_end});
	endtask

	task automatic send_l1a(input logic [23:0] num, input logic ph);
		l1a_num   <= num;
		l1a_phase <= ph;
		l1a_valid <= 1'b1;
		do @(negedge RCLK); while (!l1a_ready);
		@(posedge RCLK);
		l1a_sent++;
	endtask

	task automatic send_sample(input logic [13:0] w);
		{smp_movlp, smp_ovlp, smp_data} <= w;
		smp_valid <= 1'b1;
		do @(negedge RCLK); while (!smp_ready);
		@(posedge RCLK);
		smp_written++;
	endtask

	task automatic run_test(input int t);
		int first;
		cur_name = t_name[t];
		samp_max <= 7'(t_smax[t]);
		warn     <= t_warn[t][0];
		stall_on <= t_stall[t][0];
		hold_out <= t_hold[t][0];
		afl_seen = 1'b0;
		first    = ev;
		for (int k = 0; k < t_nevt[t]; k++)
			build_frame(first + k, t_nevt[t] - k, t_smax[t], t_warn[t][0]);
		for (int k = 0; k < t_nevt[t]; k++)   // All triggers queued ahead of samples
			send_l1a(e_num[first + k], e_phase[first + k][0]);
		l1a_valid <= 1'b0;
		while (smp_q.size() != 0)
			send_sample(smp_q.pop_front());
		smp_valid <= 1'b0;
		hold_out  <= 1'b0;
		while (exp_q.size() != 0)
			@(posedge RCLK);
		ev = first + t_nevt[t];
		if (t_hold[t] != 0)
			assert (afl_seen) else stop_run("evt_buf_afl never rose while the output was held");
	endtask

	always @(posedge RCLK) begin
		if (hold_out)
			dout_ready <= 1'b0;
		else if (stall_on)
			dout_ready <= (($random(seed) & 3) != 0);
		else
			dout_ready <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Output and status checks between edges
	//////////////////////////////////////////////////////////////////////
	always @(negedge RCLK) begin : out_monitor
		int held;
		int trg_held;
		if (running) begin
			held     = smp_written - smp_popped;
			trg_held = l1a_sent - l1a_done;
			if (dout_valid && exp_q.size() != 0 && exp_q[0][18])
				held = held - 1;   // Sample sitting in the output register
			if (dout_valid && exp_q.size() != 0 && exp_q[0][17])
				trg_held = trg_held - 1;   // Trigger retired with the end word
			assert (evt_buf_amt == (held < int'(samp_max) + 1))
				else report_value("evt_buf_amt", held < int'(samp_max) + 1, evt_buf_amt);
			assert (evt_buf_afl == (held >= AFL_LEVEL))
				else report_value("evt_buf_afl", held >= AFL_LEVEL, evt_buf_afl);
			assert (smp_ready == (held < SMP_DEPTH))
				else report_value("smp_ready", held < SMP_DEPTH, smp_ready);
			assert (l1a_ready == (trg_held < L1A_DEPTH))
				else report_value("l1a_ready", trg_held < L1A_DEPTH, l1a_ready);
			if (evt_buf_afl)
				afl_seen = 1'b1;
			if (dout_valid && dout_ready) begin
				if (exp_q.size() == 0) begin
					stop_run("Output word taken while no frame was expected");
				end else begin
					assert ({last_wrd, mlt_ovlp, dout} == exp_q[0][17:0])
						else report_value("output word", exp_q[0][17:0],
							{last_wrd, mlt_ovlp, dout});
					if (exp_q[0][18])
						smp_popped++;
					if (exp_q[0][17])
						l1a_done++;
					void'(exp_q.pop_front());
				end
			end
		end
	end

	initial begin
		load_records();
		repeat (16) @(posedge RCLK);
		RST_RESYNC <= 1'b0;
		@(posedge RCLK);
		running = 1'b1;
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("sim passed");
		$finish;
	end

	// Watchdog sized from the records
	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge RCLK);
		stop_run("Timeout: the frames did not finish within the time limit");
	end

endmodule

`default_nettype wire

/* bench/chanlink_testdata.txt */
# T name samp_max warn stall hold n_evt exp_words
# E l1a_num(hex) phase data_base(hex) data_step ovlp_every movlp_every
T single 15 0 0 0 1 20
E 00A5C3 1 123 5 0 0
T overlap 15 0 0 0 1 20
E 00003F 0 800 7 3 4
T queued 7 0 0 0 4 48
E 000101 1 010 1 0 0
E 000102 0 020 2 5 0
E 000103 1 030 3 0 2
E 000104 0 040 4 0 0
T stall 15 0 1 0 3 60
E 123456 1 ABC 11 2 3
E 123457 0 5A5 13 0 5
E 123458 1 0F0 17 4 0
T len0 0 1 0 0 2 10
E FFFFC0 1 FFF 0 1 1
E FFFFC1 0 000 0 0 0
T len127 127 0 1 0 1 132
E 000777 1 001 29 6 7
T afl 127 1 0 1 1 132
E 2A2A2A 0 3C3 31 9 8

/* verilog.f */
common/chanlink_pkg.sv
src/sync_fifo.sv
frame/frame_seq_fsm.sv
frame/frame_builder.sv
src/chanlink_fifo.sv
bench/chanlink_fifo_tb.sv

/* Makefile */
# Verilator build and run of the channel link testbench

VERILATOR ?= verilator
TOP       ?= chanlink_fifo_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list the targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
